// File: verilog/clear_prng_pkg.sv
// Shared constants and types for the register-clearing PRNG
// Share count, LFSR width, feedback taps and reset seed
// State and share bit permutations, PRINCE S-box table

`default_nettype none

package clear_prng_pkg;

  // Key and data shares
  parameter int unsigned NumShares = 2;

  // LFSR and wipe data width
  parameter int unsigned LfsrWidth = 64;

  typedef logic [LfsrWidth-1:0] lfsr_word_t;
  typedef logic [5:0]           perm_idx_t;

  // Galois feedback, x^64 + x^63 + x^61 + x^60 + 1
  parameter lfsr_word_t LfsrTaps = 64'hD800_0000_0000_0000;

  // Reset state, also used in place of an all-zero seed
  parameter lfsr_word_t DefaultSeed = 64'h3C5A_96E1_0F87_2BD4;

  // Output bit i takes state bit StatePerm[i]
  parameter perm_idx_t StatePerm [LfsrWidth] = '{
    6'd11, 6'd48, 6'd21, 6'd58, 6'd31, 6'd4,  6'd41, 6'd14,
    6'd51, 6'd24, 6'd61, 6'd34, 6'd7,  6'd44, 6'd17, 6'd54,
    6'd27, 6'd0,  6'd37, 6'd10, 6'd47, 6'd20, 6'd57, 6'd30,
    6'd3,  6'd40, 6'd13, 6'd50, 6'd23, 6'd60, 6'd33, 6'd6,
    6'd43, 6'd16, 6'd53, 6'd26, 6'd63, 6'd36, 6'd9,  6'd46,
    6'd19, 6'd56, 6'd29, 6'd2,  6'd39, 6'd12, 6'd49, 6'd22,
    6'd59, 6'd32, 6'd5,  6'd42, 6'd15, 6'd52, 6'd25, 6'd62,
    6'd35, 6'd8,  6'd45, 6'd18, 6'd55, 6'd28, 6'd1,  6'd38
  };

  // Share 1 bit i takes share 0 bit SharePerm[i]
  parameter perm_idx_t SharePerm [LfsrWidth] = '{
    6'd50, 6'd7,  6'd28, 6'd49, 6'd6,  6'd27, 6'd48, 6'd5,
    6'd26, 6'd47, 6'd4,  6'd25, 6'd46, 6'd3,  6'd24, 6'd45,
    6'd2,  6'd23, 6'd44, 6'd1,  6'd22, 6'd43, 6'd0,  6'd21,
    6'd42, 6'd63, 6'd20, 6'd41, 6'd62, 6'd19, 6'd40, 6'd61,
    6'd18, 6'd39, 6'd60, 6'd17, 6'd38, 6'd59, 6'd16, 6'd37,
    6'd58, 6'd15, 6'd36, 6'd57, 6'd14, 6'd35, 6'd56, 6'd13,
    6'd34, 6'd55, 6'd12, 6'd33, 6'd54, 6'd11, 6'd32, 6'd53,
    6'd10, 6'd31, 6'd52, 6'd9,  6'd30, 6'd51, 6'd8,  6'd29
  };

  // PRINCE 4-bit S-box
  parameter logic [3:0] PrinceSbox [16] = '{
    4'hB, 4'hF, 4'h3, 4'h2, 4'hA, 4'hC, 4'h9, 4'h1,
    4'h6, 4'h7, 4'h8, 4'h0, 4'hE, 4'h5, 4'hD, 4'h4
  };

endpackage

`default_nettype wire

// File: verilog/entropy_packer.sv
// Entropy word packer
// Collects Width/EntropyWidth entropy words into one seed word,
// first word in the low bits, and flags the full word for one cycle

`timescale 1ns/1ps
`default_nettype none

module entropy_packer import clear_prng_pkg::*; #(
  parameter int unsigned Width        = 64,
  parameter int unsigned EntropyWidth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    wvalid_i,
  input  logic [EntropyWidth-1:0] wdata_i,
  output logic                    rvalid_o,
  output lfsr_word_t              rdata_o
);

  // Words per seed, counter at least one bit wide
  localparam int unsigned NumWords = Width / EntropyWidth;
  localparam int unsigned CntW     = (NumWords > 1) ? $clog2(NumWords) : 1;

  logic [CntW-1:0]  cnt_q;
  logic             last_word;
  logic             rvalid_q;
  logic [Width-1:0] buffer_q;

  // Final word of the current fill
  assign last_word = wvalid_i && (cnt_q == CntW'(NumWords - 1));

  // Word counter restarts on its own after the last word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= last_word;
      if (last_word) begin
        cnt_q <= '0;
      end else if (wvalid_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Each word lands in its slot, low word first
  always_ff @(posedge clk_i) begin
    if (wvalid_i) begin
      buffer_q[cnt_q*EntropyWidth +: EntropyWidth] <= wdata_i;
    end
  end

  // Full word stays in the buffer during the valid cycle
  assign rvalid_o = rvalid_q;
  assign rdata_o  = buffer_q;

endmodule

`default_nettype wire

// File: verilog/gal_lfsr.sv
// Galois LFSR for the clearing PRNG
// Seed load with zero-seed substitution, single step per enable,
// state permutation followed by a PRINCE S-box layer on the output

`timescale 1ns/1ps
`default_nettype none

module gal_lfsr import clear_prng_pkg::*; #(
  parameter int unsigned Width = 64
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       seed_en_i,
  input  lfsr_word_t seed_i,
  input  logic       lfsr_en_i,
  output lfsr_word_t state_o
);

  logic [Width-1:0] state_q;
  logic [Width-1:0] state_d;
  logic [Width-1:0] seed_safe;
  logic [Width-1:0] state_step;
  logic [Width-1:0] state_perm;

  // An all-zero seed would lock the LFSR
  assign seed_safe = (seed_i == '0) ? DefaultSeed : seed_i;

  // Galois step, shift right and fold in the taps on bit 0
  assign state_step = {1'b0, state_q[Width-1:1]} ^ ({Width{state_q[0]}} & LfsrTaps);

  // Seed load wins over a step
  always_comb begin
    state_d = state_q;
    if (seed_en_i) begin
      state_d = seed_safe;
    end else if (lfsr_en_i) begin
      state_d = state_step;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DefaultSeed;
    end else begin
      state_q <= state_d;
    end
  end

  // Bit permutation of the raw state
  for (genvar i = 0; i < Width; i++) begin : gen_state_perm
    assign state_perm[i] = state_q[StatePerm[i]];
  end

  // Non-linear layer, one S-box per nibble
  for (genvar n = 0; n < Width / 4; n++) begin : gen_sbox
    assign state_o[4*n +: 4] = PrinceSbox[state_perm[4*n +: 4]];
  end

endmodule

`default_nettype wire

// File: verilog/clear_prng.sv
// Clearing PRNG producing two shares of wipe data
// Data and reseed request/acknowledge control, reseed has priority
// Entropy packing into a full seed, LFSR, share 1 permutation

`timescale 1ns/1ps
`default_nettype none

module clear_prng import clear_prng_pkg::*; #(
  parameter int unsigned Width        = 64,
  parameter int unsigned EntropyWidth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Consumer side
  input  logic                    data_req_i,
  output logic                    data_ack_o,
  output lfsr_word_t              data_o [NumShares],
  input  logic                    reseed_req_i,
  output logic                    reseed_ack_o,

  // Entropy source
  output logic                    entropy_req_o,
  input  logic                    entropy_ack_i,
  input  logic [EntropyWidth-1:0] entropy_i
);

  logic       seed_valid;
  lfsr_word_t seed;
  logic       lfsr_en;
  lfsr_word_t lfsr_state;

  // Data is served only when no reseed is pending
  assign data_ack_o = reseed_req_i ? 1'b0 : data_req_i;

  // Step once per accepted data request
  assign lfsr_en = data_req_i & data_ack_o;

  // Keep asking for entropy until the seed is complete
  assign entropy_req_o = reseed_req_i & ~seed_valid;

  // Complete seed closes the reseed handshake
  assign reseed_ack_o = seed_valid;

  entropy_packer #(
    .Width        ( Width        ),
    .EntropyWidth ( EntropyWidth )
  ) u_entropy_packer (
    .clk_i    ( clk_i         ),
    .rst_ni   ( rst_ni        ),
    .wvalid_i ( entropy_ack_i ),
    .wdata_i  ( entropy_i     ),
    .rvalid_o ( seed_valid    ),
    .rdata_o  ( seed          )
  );

  gal_lfsr #(
    .Width ( Width )
  ) u_gal_lfsr (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .seed_en_i ( seed_valid ),
    .seed_i    ( seed       ),
    .lfsr_en_i ( lfsr_en    ),
    .state_o   ( lfsr_state )
  );

  // Share 0 is the non-linear LFSR output
  assign data_o[0] = lfsr_state;

  // Share 1 is a fixed reordering of share 0
  for (genvar i = 0; i < Width; i++) begin : gen_share_perm
    assign data_o[1][i] = lfsr_state[SharePerm[i]];
  end

endmodule

`default_nettype wire

// File: verilog/key_wipe.sv
// Two-share key register bank
// Key load, pending reseed and wipe flags,
// overwrite of both shares with pseudo-random data on a wipe

`timescale 1ns/1ps
`default_nettype none

module key_wipe import clear_prng_pkg::*; #(
  parameter int unsigned Width = 64
) (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Host side
  input  logic       load_i,
  input  lfsr_word_t key_i [NumShares],
  input  logic       wipe_i,
  input  logic       reseed_i,
  output logic       busy_o,
  output lfsr_word_t key_o [NumShares],

  // PRNG side
  output logic       data_req_o,
  input  logic       data_ack_i,
  input  lfsr_word_t data_i [NumShares],
  output logic       reseed_req_o,
  input  logic       reseed_ack_i
);

  logic             reseed_q;
  logic             wipe_q;
  logic             wipe_done;
  logic             key_load;
  logic [Width-1:0] key_q [NumShares];

  // Wipe waits behind a pending reseed
  assign reseed_req_o = reseed_q;
  assign data_req_o   = wipe_q & ~reseed_q;
  assign busy_o       = reseed_q | wipe_q;

  // Random data accepted this cycle
  assign wipe_done = data_req_o & data_ack_i;

  // Loads only while idle
  assign key_load = load_i & ~busy_o;

  // Pending flags, a new strobe wins over a clearing acknowledge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reseed_q <= 1'b0;
      wipe_q   <= 1'b0;
    end else begin
      if (reseed_i) begin
        reseed_q <= 1'b1;
      end else if (reseed_ack_i) begin
        reseed_q <= 1'b0;
      end
      if (wipe_i) begin
        wipe_q <= 1'b1;
      end else if (wipe_done) begin
        wipe_q <= 1'b0;
      end
    end
  end

  // Key shares, wipe data or host key
  always_ff @(posedge clk_i) begin
    for (int s = 0; s < NumShares; s++) begin
      if (wipe_done) begin
        key_q[s] <= data_i[s];
      end else if (key_load) begin
        key_q[s] <= key_i[s];
      end
    end
  end

  assign key_o = key_q;

endmodule

`default_nettype wire

// File: verilog/clear_top.sv
// Top level of the register-clearing subsystem
// Key register bank and clearing PRNG with the entropy port

`timescale 1ns/1ps
`default_nettype none

module clear_top import clear_prng_pkg::*; #(
  parameter int unsigned Width        = 64,
  parameter int unsigned EntropyWidth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    load_i,
  input  lfsr_word_t              key_i [NumShares],
  input  logic                    wipe_i,
  input  logic                    reseed_i,
  output logic                    busy_o,
  output lfsr_word_t              key_o [NumShares],
  output logic                    entropy_req_o,
  input  logic                    entropy_ack_i,
  input  logic [EntropyWidth-1:0] entropy_i
);

  // Handshake between the key bank and the PRNG
  logic       data_req;
  logic       data_ack;
  logic       reseed_req;
  logic       reseed_ack;
  lfsr_word_t data [NumShares];

  key_wipe #(
    .Width ( Width )
  ) u_key_wipe (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .load_i       ( load_i     ),
    .key_i        ( key_i      ),
    .wipe_i       ( wipe_i     ),
    .reseed_i     ( reseed_i   ),
    .busy_o       ( busy_o     ),
    .key_o        ( key_o      ),
    .data_req_o   ( data_req   ),
    .data_ack_i   ( data_ack   ),
    .data_i       ( data       ),
    .reseed_req_o ( reseed_req ),
    .reseed_ack_i ( reseed_ack )
  );

  clear_prng #(
    .Width        ( Width        ),
    .EntropyWidth ( EntropyWidth )
  ) u_clear_prng (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .data_req_i    ( data_req      ),
    .data_ack_o    ( data_ack      ),
    .data_o        ( data          ),
    .reseed_req_i  ( reseed_req    ),
    .reseed_ack_o  ( reseed_ack    ),
    .entropy_req_o ( entropy_req_o ),
    .entropy_ack_i ( entropy_ack_i ),
    .entropy_i     ( entropy_i     )
  );

endmodule

`default_nettype wire

// File: tests/tb_clear_top_asserts.sv
// Handshake assertions for the clearing PRNG
// Bound into every clear_prng instance

`timescale 1ns/1ps
`default_nettype none

module tb_clear_top_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic reseed_req_i,
  input logic data_ack_i,
  input logic entropy_req_i,
  input logic reseed_ack_i
);

  // Reseed has priority over data
  data_ack_blocked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reseed_req_i |-> !data_ack_i)
    else $error("data acknowledge while a reseed is pending");

  // Entropy is only requested for a reseed
  entropy_req_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    entropy_req_i |-> reseed_req_i)
    else $error("entropy request without a reseed request");

  // Single-cycle reseed acknowledge
  reseed_ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reseed_ack_i |=> !reseed_ack_i)
    else $error("reseed acknowledge held longer than one cycle");

endmodule

bind clear_prng tb_clear_top_asserts u_handshake_asserts (
  .clk_i         ( clk_i         ),
  .rst_ni        ( rst_ni        ),
  .reseed_req_i  ( reseed_req_i  ),
  .data_ack_i    ( data_ack_o    ),
  .entropy_req_i ( entropy_req_o ),
  .reseed_ack_i  ( reseed_ack_o  )
);

`default_nettype wire

// File: tests/tb_clear_top.sv
// Directed testbench for the register-clearing subsystem
// Reference PRNG model, pseudo-random entropy source, compare tasks
// Watchdog bounding the whole run

`timescale 1ns/1ps
`default_nettype none

module tb_clear_top import clear_prng_pkg::*; ();

  localparam int unsigned Width        = 64;
  localparam int unsigned EntropyWidth = 32;
  localparam int unsigned NumWords     = Width / EntropyWidth;
  localparam int unsigned ResetCycles  = 8;
  // Longest single wait for a handshake
  localparam int unsigned OpCycles     = 40;
  // Handshake waits over all tests rounded up
  localparam int unsigned NumOps       = 24;
  localparam int unsigned WatchdogCycles = ResetCycles + NumOps * OpCycles + 200;

  logic                    clk;
  logic                    rst_n;
  logic                    load;
  lfsr_word_t              key_in [NumShares];
  logic                    wipe;
  logic                    reseed;
  logic                    busy;
  lfsr_word_t              key_out [NumShares];
  logic                    entropy_req;
  logic                    entropy_ack;
  logic [EntropyWidth-1:0] entropy;

  // Reference LFSR state and stimulus generator state
  lfsr_word_t  model_state;
  logic [31:0] rng_state;

  clear_top #(
    .Width        ( Width        ),
    .EntropyWidth ( EntropyWidth )
  ) u_dut (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .load_i        ( load        ),
    .key_i         ( key_in      ),
    .wipe_i        ( wipe        ),
    .reseed_i      ( reseed      ),
    .busy_o        ( busy        ),
    .key_o         ( key_out     ),
    .entropy_req_o ( entropy_req ),
    .entropy_ack_i ( entropy_ack ),
    .entropy_i     ( entropy     )
  );

  // 20 ns clock
  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Galois step of the model shifting right and folding taps in on bit 0
  function automatic lfsr_word_t model_step(input lfsr_word_t s);
    lfsr_word_t n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ LfsrTaps;
    end
    return n;
  endfunction

  // State permutation followed by one S-box per nibble
  function automatic lfsr_word_t model_share0(input lfsr_word_t s);
    lfsr_word_t p;
    lfsr_word_t o;
    for (int i = 0; i < LfsrWidth; i++) begin
      p[i] = s[StatePerm[i]];
    end
    for (int n = 0; n < LfsrWidth / 4; n++) begin
      o[4*n +: 4] = PrinceSbox[p[4*n +: 4]];
    end
    return o;
  endfunction

  // Share 1 as a reordering of share 0
  function automatic lfsr_word_t model_share1(input lfsr_word_t s0);
    lfsr_word_t o;
    for (int i = 0; i < LfsrWidth; i++) begin
      o[i] = s0[SharePerm[i]];
    end
    return o;
  endfunction

  // Stimulus LFSR stepped once per bit taken
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int unsigned k = 0; k < n; k++) begin
      rng_state = rng_state[0] ? ((rng_state >> 1) ^ 32'hD000_0001) : (rng_state >> 1);
      v = {v[62:0], rng_state[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string why);
    $display("TEST FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_word(input string name, input lfsr_word_t exp, input lfsr_word_t act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
      abort_run("word value mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %b actual %b", $time, name, exp, act);
      abort_run("flag value mismatch");
    end
  endtask

  // All strobes start and end right after a falling edge
  task automatic load_key(input lfsr_word_t k0, input lfsr_word_t k1);
    load      = 1'b1;
    key_in[0] = k0;
    key_in[1] = k1;
    @(negedge clk);
    load = 1'b0;
  endtask

  task automatic start_wipe();
    wipe = 1'b1;
    @(negedge clk);
    wipe = 1'b0;
  endtask

  task automatic start_reseed();
    reseed = 1'b1;
    @(negedge clk);
    reseed = 1'b0;
  endtask

  task automatic wait_idle();
    int unsigned n;
    n = 0;
    while (busy) begin
      if (n >= OpCycles) begin
        abort_run("busy_o stayed high past the handshake limit");
      end
      @(negedge clk);
      n++;
    end
  endtask

  // Answer the entropy request word by word at random delays
  task automatic feed_entropy(input logic zero, output lfsr_word_t seed);
    int unsigned delay;
    int unsigned n;
    logic [EntropyWidth-1:0] word;
    seed = '0;
    for (int unsigned w = 0; w < NumWords; w++) begin
      delay = int'(rand_bits(2));
      repeat (delay) @(negedge clk);
      n = 0;
      while (!entropy_req) begin
        if (n >= OpCycles) begin
          abort_run("entropy_req_o did not rise during a reseed");
        end
        @(negedge clk);
        n++;
      end
      word = zero ? '0 : EntropyWidth'(rand_bits(EntropyWidth));
      seed[w*EntropyWidth +: EntropyWidth] = word;
      entropy_ack = 1'b1;
      entropy     = word;
      @(negedge clk);
      entropy_ack = 1'b0;
    end
  endtask

  // An all-zero seed falls back to the reset seed
  task automatic reseed_model(input lfsr_word_t seed);
    model_state = (seed == '0) ? DefaultSeed : seed;
  endtask

  // Both shares against the model before the model advances
  task automatic expect_wipe_result();
    lfsr_word_t s0;
    s0 = model_share0(model_state);
    check_word("key_o[0]", s0, key_out[0]);
    check_word("key_o[1]", model_share1(s0), key_out[1]);
    model_state = model_step(model_state);
  endtask

  task automatic test_reset_load();
    lfsr_word_t k0;
    lfsr_word_t k1;
    check_bit("busy_o", 1'b0, busy);
    check_bit("entropy_req_o", 1'b0, entropy_req);
    k0 = rand_bits(64);
    k1 = rand_bits(64);
    load_key(k0, k1);
    check_word("key_o[0]", k0, key_out[0]);
    check_word("key_o[1]", k1, key_out[1]);
    check_bit("busy_o", 1'b0, busy);
  endtask

  task automatic test_first_wipe();
    lfsr_word_t held;
    held = key_out[0];
    start_wipe();
    // Request pending and key untouched one cycle in
    check_bit("busy_o", 1'b1, busy);
    check_word("key_o[0]", held, key_out[0]);
    @(negedge clk);
    expect_wipe_result();
    check_bit("busy_o", 1'b0, busy);
  endtask

  task automatic test_wipe_sequence();
    lfsr_word_t prev;
    for (int i = 0; i < 4; i++) begin
      prev = key_out[0];
      start_wipe();
      wait_idle();
      expect_wipe_result();
      if (key_out[0] === prev) begin
        abort_run("two successive wipes produced the same share 0");
      end
    end
  endtask

  task automatic test_reseed();
    lfsr_word_t seed;
    start_reseed();
    check_bit("busy_o", 1'b1, busy);
    check_bit("entropy_req_o", 1'b1, entropy_req);
    feed_entropy(1'b0, seed);
    wait_idle();
    reseed_model(seed);
    start_wipe();
    wait_idle();
    expect_wipe_result();
  endtask

  task automatic test_wipe_during_reseed();
    lfsr_word_t seed;
    lfsr_word_t held [NumShares];
    start_reseed();
    start_wipe();
    held = key_out;
    // Ignored while busy
    load_key(rand_bits(64), rand_bits(64));
    check_word("key_o[0]", held[0], key_out[0]);
    check_word("key_o[1]", held[1], key_out[1]);
    feed_entropy(1'b0, seed);
    reseed_model(seed);
    wait_idle();
    expect_wipe_result();
  endtask

  task automatic test_zero_reseed();
    lfsr_word_t seed;
    start_reseed();
    feed_entropy(1'b1, seed);
    wait_idle();
    reseed_model(seed);
    start_wipe();
    wait_idle();
    expect_wipe_result();
  endtask

  // Ends a run that stalls anywhere
  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    abort_run("watchdog expired before the tests completed");
  end

  initial begin
    rng_state   = 32'h5100;
    model_state = DefaultSeed;
    rst_n       = 1'b0;
    load        = 1'b0;
    wipe        = 1'b0;
    reseed      = 1'b0;
    entropy_ack = 1'b0;
    entropy     = '0;
    key_in[0]   = '0;
    key_in[1]   = '0;
    repeat (ResetCycles) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_reset_load();
    test_first_wipe();
    test_wipe_sequence();
    test_reseed();
    test_wipe_during_reseed();
    test_zero_reseed();

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
verilog/clear_prng_pkg.sv
verilog/entropy_packer.sv
verilog/gal_lfsr.sv
verilog/clear_prng.sv
verilog/key_wipe.sv
verilog/clear_top.sv
tests/tb_clear_top_asserts.sv
tests/tb_clear_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_clear_top \
  -f verilog.f -o tb_clear_top \
  && ./obj_dir/tb_clear_top > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q '^TEST OK$' sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
